// ==== goose_pkg.sv ====
// Geometry and colour constants plus raster, scene, colour and layer types
package goose_pkg;

    // Coordinate widths
    localparam int COORD_W = 11;  // Scroll offset and sprite positions
    localparam int SCAN_W  = 10;  // Raster counters

    // Scene
    localparam int FLOOR_Y = 240;  // First ground row
    localparam int SPAWN_X = 640;  // First obstacle column at zero scroll

    // Goose box
    localparam int GOOSE_X      = 50;
    localparam int GOOSE_Y_BASE = 200;  // Top row when standing
    localparam int GOOSE_W      = 30;
    localparam int GOOSE_H      = 40;

    // Obstacles
    localparam int ION_W           = 20;
    localparam int ION_H           = 40;
    localparam int UW_SIZE         = 30;
    localparam int UW_SPAWN_OFFSET = 250;  // Emblem trails the railway
    localparam int OUTLINE_PX      = 2;

    // Pattern drawn when the obstacle type bit is low
    typedef enum logic {
        OBS_DASHED,
        OBS_OUTLINE
    } obstacle_kind_t;

    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    // Raster position from the video timing
    typedef struct packed {
        logic [SCAN_W-1:0] haddr;
        logic [SCAN_W-1:0] vaddr;
        logic              display_on;
    } scan_t;

    // Game state from the game controller
    typedef struct packed {
        logic [COORD_W-1:0] scrolladdr;
        logic [6:0]         jump_pos;
        logic [1:0]         obstacle_select;
        logic [1:0]         obstacle_type;
        logic               game_over;
        logic               game_start_blink;
    } scene_t;

    // Highest priority first
    typedef struct packed {
        logic goose;
        logic ion;
        logic uw;
        logic ground;
        logic sky;
    } layer_t;

    localparam rgb_t SKY_RGB    = '{r: 2'd0, g: 2'd3, b: 2'd3};
    localparam rgb_t GROUND_RGB = '{r: 2'd1, g: 2'd1, b: 2'd1};
    localparam rgb_t ION_RGB    = '{r: 2'd1, g: 2'd1, b: 2'd1};
    localparam rgb_t UW_RGB     = '{r: 2'd3, g: 2'd3, b: 2'd3};
    localparam rgb_t DEAD_RGB   = '{r: 2'd3, g: 2'd0, b: 2'd0};
    localparam rgb_t BLANK_RGB  = '{r: 2'd0, g: 2'd0, b: 2'd0};

endpackage

// ==== goose_sprite.sv ====
// Goose layer generator with body-part lookup and per-part colour
`timescale 1ns/1ps

module goose_sprite import goose_pkg::*; #(
    parameter int GOOSE_X      = goose_pkg::GOOSE_X,
    parameter int GOOSE_Y_BASE = goose_pkg::GOOSE_Y_BASE,
    parameter int GOOSE_W      = goose_pkg::GOOSE_W,
    parameter int GOOSE_H      = goose_pkg::GOOSE_H
) (
    input  logic       clk,
    input  logic       sys_rst,
    input  scan_t      scan,
    input  logic [6:0] jump_pos,
    input  logic       game_over,
    input  logic       blink,
    output logic       goose_on,
    output rgb_t       goose_rgb
);

    localparam logic [COORD_W-1:0] BOX_X  = COORD_W'(GOOSE_X);
    localparam logic [COORD_W-1:0] BOX_W  = COORD_W'(GOOSE_W);
    localparam logic [COORD_W-1:0] BOX_H  = COORD_W'(GOOSE_H);
    localparam logic [COORD_W-1:0] BASE_Y = COORD_W'(GOOSE_Y_BASE);

    // Part palette
    localparam rgb_t BEAK_RGB  = '{r: 2'd3, g: 2'd2, b: 2'd1};
    localparam rgb_t WHITE_RGB = '{r: 2'd3, g: 2'd3, b: 2'd3};
    localparam rgb_t BLACK_RGB = '{r: 2'd0, g: 2'd0, b: 2'd0};
    localparam rgb_t TAIL_RGB  = '{r: 2'd2, g: 2'd1, b: 2'd0};
    localparam rgb_t BROWN_RGB = '{r: 2'd2, g: 2'd2, b: 2'd1};
    localparam rgb_t IDLE_RGB  = '{r: 2'd3, g: 2'd3, b: 2'd0};  // Yellow when nothing hit

    logic [COORD_W-1:0] hx;
    logic [COORD_W-1:0] vy;
    logic [COORD_W-1:0] top_y;
    logic [COORD_W-1:0] loc_x;
    logic [COORD_W-1:0] loc_y;
    logic               in_box;
    logic               draw;
    logic               part_hit;
    rgb_t               part_rgb;

    function automatic logic in_range(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    assign hx    = COORD_W'(scan.haddr);
    assign vy    = COORD_W'(scan.vaddr);
    assign top_y = BASE_Y - COORD_W'(jump_pos);  // Jump raises the box
    assign loc_x = hx - BOX_X;
    assign loc_y = vy - top_y;

    assign in_box = (hx >= BOX_X) && (loc_x < BOX_W) && (vy >= top_y) && (loc_y < BOX_H);
    assign draw   = in_box && blink && scan.display_on;

    // Parts checked in priority order, first match wins
    always_comb begin
        int x;
        int y;
        int wing_lo;
        int neck_step;

        x = int'(loc_x);
        y = int'(loc_y);
        // Left edge of the raised wing, also where its black edge sits
        wing_lo   = (y < 16) ? 6 : ((y < 19) ? y - 9 : 10);
        neck_step = (y - 17) >>> 1;  // Neck leans one column left every two rows
        part_hit  = 1'b1;

        if (in_range(y, 13, 14) && in_range(x, 27, 28)) begin
            part_rgb = BEAK_RGB;
        end else if (in_range(y, 12, 13) && x == 24) begin  // Eye
            part_rgb = WHITE_RGB;
        end else if (in_range(y, 13, 14) && in_range(x, 22, 23)) begin  // Cheek
            part_rgb = WHITE_RGB;
        end else if (in_range(y, 34, 35) && in_range(x, 12, 18)) begin  // Belly
            part_rgb = WHITE_RGB;
        end else if (in_range(y, 11, 16) && in_range(x, 22, 26)) begin  // Head
            part_rgb = BLACK_RGB;
        end else if (in_range(y, 17, 24) && in_range(x, 20 - neck_step, 21 - neck_step)) begin
            part_rgb = BLACK_RGB;
        end else if (in_range(y, 14, 24) && x == wing_lo) begin  // Wing edge
            part_rgb = BLACK_RGB;
        end else if (in_range(y, 36, 39) && (x == 12 || x == 15)) begin  // Legs
            part_rgb = BLACK_RGB;
        end else if (in_range(y, 29, 34) && in_range(x, 6, in_range(y, 32, 33) ? 8 : 7)) begin
            part_rgb = TAIL_RGB;
        end else if (in_range(y, 14, 24) && in_range(x, wing_lo, y - 6)) begin  // Wing
            part_rgb = BROWN_RGB;
        end else if ((in_range(y, 25, 28) && in_range(x, 10, 22)) ||
                     (in_range(y, 29, 32) && in_range(x, 9, 22)) ||
                     (in_range(y, 33, 35) && in_range(x, 9, 21))) begin  // Body
            part_rgb = BROWN_RGB;
        end else begin
            part_hit = 1'b0;
            part_rgb = IDLE_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            goose_on <= 1'b0;
        end else begin
            goose_on <= draw && part_hit;
        end
    end

    // Whole bird turns red once the game is lost
    always_ff @(posedge clk) begin
        if (draw && part_hit) begin
            goose_rgb <= game_over ? DEAD_RGB : part_rgb;
        end else begin
            goose_rgb <= IDLE_RGB;
        end
    end

endmodule

// ==== obstacle_sprite.sv ====
// Obstacle layer generator with parameterized box and pattern kind
`timescale 1ns/1ps

module obstacle_sprite import goose_pkg::*; #(
    parameter int             OBS_W        = 20,
    parameter int             OBS_H        = 40,
    parameter int             SPAWN_OFFSET = 0,
    parameter obstacle_kind_t KIND         = OBS_DASHED
) (
    input  logic               clk,
    input  logic               sys_rst,
    input  scan_t              scan,
    input  logic [COORD_W-1:0] scrolladdr,
    input  logic               select,
    input  logic               solid,
    output logic               obs_on
);

    localparam logic [COORD_W-1:0] BOX_W   = COORD_W'(OBS_W);
    localparam logic [COORD_W-1:0] BOX_H   = COORD_W'(OBS_H);
    localparam logic [COORD_W-1:0] TOP_Y   = COORD_W'(FLOOR_Y - OBS_H);  // Sits on the floor
    localparam logic [COORD_W-1:0] FLOOR_C = COORD_W'(FLOOR_Y);
    localparam logic [COORD_W-1:0] START_X = COORD_W'(SPAWN_X + SPAWN_OFFSET);
    localparam logic [COORD_W-1:0] EDGE    = COORD_W'(OUTLINE_PX);

    logic [COORD_W-1:0] hx;
    logic [COORD_W-1:0] vy;
    logic [COORD_W-1:0] left_x;
    logic [COORD_W-1:0] off_x;
    logic [COORD_W-1:0] off_y;
    logic               in_box;
    logic               outline;
    logic               pattern;

    assign hx     = COORD_W'(scan.haddr);
    assign vy     = COORD_W'(scan.vaddr);
    assign left_x = START_X - scrolladdr;  // Wraps modulo 2^11
    assign off_x  = hx - left_x;
    assign off_y  = vy - TOP_Y;

    assign in_box = (hx >= left_x) && (off_x < BOX_W) && (vy >= TOP_Y) && (vy < FLOOR_C);

    assign outline = (off_x < EDGE) || (off_x >= BOX_W - EDGE) ||
                     (off_y < EDGE) || (off_y >= BOX_H - EDGE);

    always_comb begin
        if (solid) begin
            pattern = 1'b1;
        end else if (KIND == OBS_DASHED) begin
            pattern = (scan.vaddr[2:0] < 3'd4);  // 4 rows on, 4 off
        end else begin
            pattern = outline;
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            obs_on <= 1'b0;
        end else begin
            obs_on <= scan.display_on && select && in_box && pattern;
        end
    end

endmodule

// ==== layer_compositor.sv ====
// Sky and ground band registers, layer priority mux, blanking and collision
`timescale 1ns/1ps

module layer_compositor import goose_pkg::*; (
    input  logic  clk,
    input  logic  sys_rst,
    input  scan_t scan,
    input  logic  goose_on,
    input  rgb_t  goose_rgb,
    input  logic  ion_on,
    input  logic  uw_on,
    output rgb_t  pixel,
    output logic  collision
);

    localparam logic [SCAN_W-1:0] FLOOR_ROW = SCAN_W'(FLOOR_Y);

    logic   sky_q;
    logic   ground_q;
    layer_t layers;
    rgb_t   mix_rgb;

    // Bands delayed one cycle to line up with the sprite layers
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            sky_q    <= 1'b0;
            ground_q <= 1'b0;
        end else begin
            sky_q    <= scan.display_on && (scan.vaddr < FLOOR_ROW);
            ground_q <= scan.display_on && (scan.vaddr >= FLOOR_ROW);
        end
    end

    assign layers = '{goose: goose_on, ion: ion_on, uw: uw_on, ground: ground_q, sky: sky_q};

    always_comb begin
        if (layers.goose) begin
            mix_rgb = goose_rgb;
        end else if (layers.ion) begin
            mix_rgb = ION_RGB;  // Railway drawn over the emblem
        end else if (layers.uw) begin
            mix_rgb = UW_RGB;
        end else if (layers.ground) begin
            mix_rgb = GROUND_RGB;
        end else if (layers.sky) begin
            mix_rgb = SKY_RGB;
        end else begin
            mix_rgb = BLANK_RGB;
        end
    end

    // Blank on the live display_on, not the delayed one
    assign pixel = scan.display_on ? mix_rgb : BLANK_RGB;

    // Only obstacles count, not the ground
    assign collision = layers.goose && (layers.ion || layers.uw);

endmodule

// ==== goose_renderer.sv ====
// Top level of the pixel renderer, goose and obstacle layers into the compositor
`timescale 1ns/1ps

module goose_renderer import goose_pkg::*; #(
    parameter int GOOSE_X         = goose_pkg::GOOSE_X,
    parameter int GOOSE_Y_BASE    = goose_pkg::GOOSE_Y_BASE,
    parameter int GOOSE_W         = goose_pkg::GOOSE_W,
    parameter int GOOSE_H         = goose_pkg::GOOSE_H,
    parameter int ION_W           = goose_pkg::ION_W,
    parameter int ION_H           = goose_pkg::ION_H,
    parameter int UW_SIZE         = goose_pkg::UW_SIZE,
    parameter int UW_SPAWN_OFFSET = goose_pkg::UW_SPAWN_OFFSET
) (
    input  logic   clk,
    input  logic   sys_rst,
    input  scan_t  scan,
    input  scene_t scene,
    output rgb_t   pixel,
    output logic   collision
);

    logic goose_on;
    rgb_t goose_rgb;
    logic ion_on;
    logic uw_on;

    goose_sprite #(
        .GOOSE_X      (GOOSE_X),
        .GOOSE_Y_BASE (GOOSE_Y_BASE),
        .GOOSE_W      (GOOSE_W),
        .GOOSE_H      (GOOSE_H)
    ) i_goose_sprite (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .scan      (scan),
        .jump_pos  (scene.jump_pos),
        .game_over (scene.game_over),
        .blink     (scene.game_start_blink),
        .goose_on  (goose_on),
        .goose_rgb (goose_rgb)
    );

    // Railway, dashed unless its type bit is set
    obstacle_sprite #(
        .OBS_W        (ION_W),
        .OBS_H        (ION_H),
        .SPAWN_OFFSET (0),
        .KIND         (OBS_DASHED)
    ) i_ion_sprite (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .scan       (scan),
        .scrolladdr (scene.scrolladdr),
        .select     (scene.obstacle_select[0]),
        .solid      (scene.obstacle_type[0]),
        .obs_on     (ion_on)
    );

    // Square emblem further down the track
    obstacle_sprite #(
        .OBS_W        (UW_SIZE),
        .OBS_H        (UW_SIZE),
        .SPAWN_OFFSET (UW_SPAWN_OFFSET),
        .KIND         (OBS_OUTLINE)
    ) i_uw_sprite (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .scan       (scan),
        .scrolladdr (scene.scrolladdr),
        .select     (scene.obstacle_select[1]),
        .solid      (scene.obstacle_type[1]),
        .obs_on     (uw_on)
    );

    layer_compositor i_layer_compositor (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .scan      (scan),
        .goose_on  (goose_on),
        .goose_rgb (goose_rgb),
        .ion_on    (ion_on),
        .uw_on     (uw_on),
        .pixel     (pixel),
        .collision (collision)
    );

endmodule

// ==== goose_renderer_props.sv ====
// Concurrent assertions on blanking, collision and post-reset state of the renderer
`timescale 1ns/1ps

module goose_renderer_props import goose_pkg::*; (
    input logic   clk,
    input logic   sys_rst,
    input scan_t  scan,
    input scene_t scene,
    input logic   goose_on,
    input rgb_t   pixel,
    input logic   collision
);

    // Blank while display_on is low and in the cycle after it was sampled low
    blank_when_off: assert property (@(posedge clk) disable iff (sys_rst)
        !scan.display_on || !$past(scan.display_on) |-> pixel == BLANK_RGB)
        else $error("pixel not blank while display_on is low or just after");

    // Only a goose that was drawn can collide
    collision_needs_goose: assert property (@(posedge clk) disable iff (sys_rst)
        collision |-> goose_on && $past(scene.game_start_blink && scan.display_on))
        else $error("collision raised without a drawn goose");

    reset_state_clean: assert property (@(posedge clk)
        $fell(sys_rst) |-> (pixel == BLANK_RGB) && !collision)
        else $error("pixel or collision not cleared after reset");

endmodule

bind goose_renderer goose_renderer_props i_goose_renderer_props (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .scan      (scan),
    .scene     (scene),
    .goose_on  (goose_on),
    .pixel     (pixel),
    .collision (collision)
);

// ==== tb_goose_renderer.sv ====
// Testbench with clock, reset, golden vector reader, checks, timeout and summary
`timescale 1ns/1ps

module tb_goose_renderer import goose_pkg::*; ();

    localparam int MAX_VECTORS = 64;
    localparam int FIELDS      = 11;  // Words per vector in the golden file

    logic   clk;
    logic   sys_rst;
    scan_t  scan;
    scene_t scene;
    rgb_t   pixel;
    logic   collision;

    // Word 0 holds the vector count and the vectors follow
    logic [11:0] golden_mem [0:MAX_VECTORS*FIELDS];

    int num_vectors;
    int cycle_limit = 0;
    int cycle_count = 0;
    int error_count;
    int check_count;

    goose_renderer i_goose_renderer (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .scan      (scan),
        .scene     (scene),
        .pixel     (pixel),
        .collision (collision)
    );

    initial clk = 1'b0;

    always #50 clk = ~clk;  // 100 ns period

    // Watchdog limit is set once the vector count is known
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run still going after %0d clock cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string field, input int k,
                               input logic [7:0] actual, input logic [7:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t: vector %0d %s is %0h, expected %0h",
                     $time, k, field, actual, expected);
        end
    endtask

    task automatic drive_vector(input int k);
        logic [9:0] base;

        base                   = 10'(1 + k * FIELDS);
        scan.haddr             = golden_mem[base][9:0];
        scan.vaddr             = golden_mem[base + 10'd1][9:0];
        scan.display_on        = golden_mem[base + 10'd2][0];
        scene.scrolladdr       = golden_mem[base + 10'd3][10:0];
        scene.jump_pos         = golden_mem[base + 10'd4][6:0];
        scene.obstacle_select  = golden_mem[base + 10'd5][1:0];
        scene.obstacle_type    = golden_mem[base + 10'd6][1:0];
        scene.game_over        = golden_mem[base + 10'd7][0];
        scene.game_start_blink = golden_mem[base + 10'd8][0];
    endtask

    // Expected pixel packed as {r, g, b}
    task automatic check_vector(input int k);
        logic [9:0] base;

        base = 10'(1 + k * FIELDS);
        check_value("pixel", k, {2'b00, pixel}, {2'b00, golden_mem[base + 10'd9][5:0]});
        check_value("collision", k, {7'd0, collision}, {7'd0, golden_mem[base + 10'd10][0]});
    endtask

    initial begin
        int k;

        error_count     = 0;
        check_count     = 0;
        sys_rst         = 1'b1;
        scan            = '0;
        scan.display_on = 1'b1;  // Raster running through reset
        scene           = '0;

        $readmemh("goose_renderer_golden.txt", golden_mem);
        num_vectors = int'(golden_mem[0]);
        if (num_vectors < 1 || num_vectors > MAX_VECTORS) begin
            $display("Golden file gave an unusable vector count of %0d", num_vectors);
            error_count++;
            num_vectors = 0;
        end
        cycle_limit = 2 * num_vectors + 20;

        repeat (2) @(posedge clk);
        #1;
        sys_rst = 1'b0;

        // Registers hold their reset state here
        check_value("reset pixel", -1, {2'b00, pixel}, 8'h00);
        check_value("reset collision", -1, {7'd0, collision}, 8'h00);

        // Post-reset state stays on pixel for one more cycle
        @(posedge clk);
        #1;

        if (num_vectors > 0) begin
            drive_vector(0);
        end

        // One cycle latency with display_on held until the check is done
        for (k = 0; k < num_vectors; k++) begin
            @(posedge clk);
            #1;
            check_vector(k);
            if (k + 1 < num_vectors) begin
                drive_vector(k + 1);
            end
        end

        @(posedge clk);
        $display("Summary: %0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== goose_renderer_golden.txt ====
// First word is the vector count, then one vector per line, all fields in hex:
// haddr vaddr display_on scrolladdr jump_pos select type game_over blink pixel{r,g,b} collision
02F
// Blanking
064 064 0 000 00 0 0 0 1 00 0
04D 0D5 0 000 00 0 0 0 1 00 0
// Sky and ground bands
12C 064 1 000 00 0 0 0 0 0F 0
12C 0EF 1 000 00 0 0 0 0 0F 0
12C 0F0 1 000 00 0 0 0 0 15 0
12C 190 1 000 00 0 0 0 0 15 0
// Goose parts, standing
04D 0D5 1 000 00 0 0 0 1 39 0 // beak
04A 0D4 1 000 00 0 0 0 1 3F 0 // eye
048 0D6 1 000 00 0 0 0 1 3F 0 // cheek
04B 0D7 1 000 00 0 0 0 1 00 0 // head
03E 0DC 1 000 00 0 0 0 1 29 0 // wing
03C 0DC 1 000 00 0 0 0 1 00 0 // wing edge
041 0E6 1 000 00 0 0 0 1 29 0 // body
041 0EA 1 000 00 0 0 0 1 3F 0 // belly
038 0E6 1 000 00 0 0 0 1 24 0 // tail
03E 0ED 1 000 00 0 0 0 1 00 0 // legs
032 0C8 1 000 00 0 0 0 1 0F 0 // empty box corner
031 0D5 1 000 00 0 0 0 1 0F 0 // left of the box
// Jump of 20, blink low, game over
04D 0C1 1 000 14 0 0 0 1 39 0
03E 0C8 1 000 14 0 0 0 1 29 0
04D 0D5 1 000 14 0 0 0 1 0F 0
04D 0D5 1 000 00 0 0 0 0 0F 0
04D 0D5 1 000 00 0 0 1 1 30 0
041 0E6 1 000 00 0 0 1 1 30 0
04A 0D4 1 000 00 0 0 1 1 30 0
// Railway at scroll 300, columns 340 to 359
154 0CD 1 12C 00 1 1 0 0 15 0
154 0CD 1 12C 00 1 0 0 0 0F 0
167 0C8 1 12C 00 1 0 0 0 15 0
15E 0CB 1 12C 00 1 0 0 0 15 0
15E 0CC 1 12C 00 1 0 0 0 0F 0
168 0C8 1 12C 00 1 1 0 0 0F 0
153 0C8 1 12C 00 1 1 0 0 0F 0
159 0C7 1 12C 00 1 1 0 0 0F 0
159 0CD 1 12C 00 0 1 0 0 0F 0
// Emblem at scroll 600, columns 290 to 319, rows 210 to 239
12C 0DC 1 258 00 2 2 0 0 3F 0
12C 0DC 1 258 00 2 0 0 0 0F 0
123 0DC 1 258 00 2 0 0 0 3F 0
13E 0DC 1 258 00 2 0 0 0 3F 0
131 0D3 1 258 00 2 0 0 0 3F 0
131 0EE 1 258 00 2 0 0 0 3F 0
140 0DC 1 258 00 2 2 0 0 0F 0
// Collision of the goose body with each obstacle
041 0E6 1 244 00 1 1 0 1 29 1
041 0E6 1 244 00 0 1 0 1 29 0
041 0E6 0 244 00 1 1 0 1 00 0
041 0E6 1 33E 00 2 2 0 1 29 1
041 0E6 1 33E 00 2 2 1 1 30 1
032 0C8 1 258 00 1 1 0 1 15 0

// ==== compile.f ====
goose_pkg.sv
goose_sprite.sv
obstacle_sprite.sv
layer_compositor.sv
goose_renderer.sv
goose_renderer_props.sv
tb_goose_renderer.sv

// ==== Makefile ====
# Verilator build and run of the goose renderer testbench

TOP = tb_goose_renderer

sim:
	verilator --binary --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
